// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// architectural widths

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;	// register and data word
	typedef logic [xlen-1:0] instr_t;	// raw instruction
	typedef logic [4:0]      reg_addr_t;	// x0..x31

	// instruction fields
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	//////////////////////////////////////////////////////////////////////
	// encodings

	// only the integer compute opcodes
	localparam opcode_t opc_op     = 7'b0110011;
	localparam opcode_t opc_op_imm = 7'b0010011;

	localparam funct3_t f3_add  = 3'b000;	// add, sub, addi
	localparam funct3_t f3_sll  = 3'b001;
	localparam funct3_t f3_slt  = 3'b010;
	localparam funct3_t f3_sltu = 3'b011;
	localparam funct3_t f3_xor  = 3'b100;
	localparam funct3_t f3_sr   = 3'b101;	// srl and sra
	localparam funct3_t f3_or   = 3'b110;
	localparam funct3_t f3_and  = 3'b111;

	// sub, sra, srai
	localparam funct7_t f7_alt = 7'b0100000;

endpackage

// File: verilog/core_pkg.sv
package core_pkg;

	//////////////////////////////////////////////////////////////////////
	// alu operation codes

	typedef logic [3:0] alu_op_t;

	localparam alu_op_t alu_add  = 4'd0;
	localparam alu_op_t alu_sub  = 4'd1;
	localparam alu_op_t alu_sll  = 4'd2;
	localparam alu_op_t alu_slt  = 4'd3;
	localparam alu_op_t alu_sltu = 4'd4;
	localparam alu_op_t alu_xor  = 4'd5;
	localparam alu_op_t alu_srl  = 4'd6;
	localparam alu_op_t alu_sra  = 4'd7;
	localparam alu_op_t alu_or   = 4'd8;
	localparam alu_op_t alu_and  = 4'd9;

	//////////////////////////////////////////////////////////////////////
	// stage payloads

	// decode to execute
	typedef struct packed {
		logic                  valid;
		logic                  wen;	// already false for rd == x0
		rv_isa_pkg::reg_addr_t rd;
		alu_op_t               alu_op;
		rv_isa_pkg::word_t     op_a;
		rv_isa_pkg::word_t     op_b;
	} dec_ex_t;

	// execute result, also the rf write request once registered
	typedef struct packed {
		logic                  valid;
		logic                  wen;
		rv_isa_pkg::reg_addr_t rd;
		rv_isa_pkg::word_t     data;
	} result_t;

endpackage

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic                  CLK,
	input  logic                  RSTn,
	input  rv_isa_pkg::reg_addr_t ra1,
	input  rv_isa_pkg::reg_addr_t ra2,
	output rv_isa_pkg::word_t     rd1,
	output rv_isa_pkg::word_t     rd2,
	input  core_pkg::result_t     wr
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	word_t regs [32];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.wen) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// x0 hardwired
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               inst_valid,
	input  rv_isa_pkg::instr_t inst,
	input  core_pkg::result_t  ex_res,
	input  core_pkg::result_t  wb_res,
	output core_pkg::dec_ex_t  dec
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	opcode_t   opcode;
	funct3_t   funct3;
	funct7_t   funct7;
	reg_addr_t rs1, rs2, rd;
	word_t     imm;
	word_t     rf_rd1, rf_rd2;
	word_t     fwd_a, fwd_b;
	alu_op_t   alu_op;
	logic      legal;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	assign legal = (opcode == opc_op) || (opcode == opc_op_imm);

	// shifts take shamt, the rest a sign-extended i-type imm
	assign imm = (funct3 == f3_sll || funct3 == f3_sr) ? {27'b0, inst[24:20]}
		: {{20{inst[31]}}, inst[31:20]};

	always_comb begin
		case (funct3)
			f3_add:  alu_op = (opcode == opc_op && funct7 == f7_alt) ? alu_sub : alu_add;
			f3_sll:  alu_op = alu_sll;
			f3_slt:  alu_op = alu_slt;
			f3_sltu: alu_op = alu_sltu;
			f3_xor:  alu_op = alu_xor;
			f3_sr:   alu_op = (funct7 == f7_alt) ? alu_sra : alu_srl;
			f3_or:   alu_op = alu_or;
			default: alu_op = alu_and;
		endcase
	end

	reg_file u_rf (
		.CLK  (CLK),
		.RSTn (RSTn),
		.ra1  (rs1),
		.ra2  (rs2),
		.rd1  (rf_rd1),
		.rd2  (rf_rd2),
		.wr   (wb_res)
	);

	//////////////////////////////////////////////////////////////////////
	// forwarding, youngest producer first

	function automatic word_t fwd(input reg_addr_t rs, input word_t rf_val);
		if (ex_res.valid && ex_res.wen && ex_res.rd == rs)
			return ex_res.data;
		else if (wb_res.valid && wb_res.wen && wb_res.rd == rs)
			return wb_res.data;
		else
			return rf_val;
	endfunction

	always_comb begin
		fwd_a = fwd(rs1, rf_rd1);
		fwd_b = fwd(rs2, rf_rd2);
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			dec <= '0;
		end else begin
			dec.valid  <= inst_valid && legal;	// bad opcode leaves an empty slot
			dec.wen    <= inst_valid && legal && (rd != '0);
			dec.rd     <= rd;
			dec.alu_op <= alu_op;
			dec.op_a   <= fwd_a;
			dec.op_b   <= (opcode == opc_op) ? fwd_b : imm;
		end
	end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
	input  core_pkg::dec_ex_t dec,
	output core_pkg::result_t ex_res
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	word_t      alu_out;
	logic [4:0] shamt;

	assign shamt = dec.op_b[4:0];

	//////////////////////////////////////////////////////////////////////
	// alu

	always_comb begin
		case (dec.alu_op)
			alu_add:
				alu_out = dec.op_a + dec.op_b;
			alu_sub:
				alu_out = dec.op_a - dec.op_b;
			alu_sll:
				alu_out = dec.op_a << shamt;
			alu_slt:
				alu_out = {31'b0, $signed(dec.op_a) < $signed(dec.op_b)};
			alu_sltu:
				alu_out = {31'b0, dec.op_a < dec.op_b};
			alu_xor:
				alu_out = dec.op_a ^ dec.op_b;
			alu_srl:
				alu_out = dec.op_a >> shamt;
			alu_sra:
				alu_out = word_t'($signed(dec.op_a) >>> shamt);	// keeps sign
			alu_or:
				alu_out = dec.op_a | dec.op_b;
			alu_and:
				alu_out = dec.op_a & dec.op_b;
			default:
				alu_out = '0;	// unused codes
		endcase
	end

	// control rides along with the result
	assign ex_res.valid = dec.valid;
	assign ex_res.wen   = dec.wen;
	assign ex_res.rd    = dec.rd;
	assign ex_res.data  = alu_out;

endmodule

// File: verilog/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage (
	input  logic              CLK,
	input  logic              RSTn,
	input  core_pkg::result_t ex_res,
	output core_pkg::result_t wb_res,
	output rv_isa_pkg::word_t num_retired
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wb_res <= '0;
		end else begin
			wb_res <= ex_res;
		end
	end

	// counted at the same edge the result lands
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			num_retired <= '0;
		end else if (ex_res.valid) begin
			num_retired <= num_retired + word_t'(1);
		end
	end

endmodule

// File: verilog/rv_int_pipe.sv
`timescale 1ns/10ps

module rv_int_pipe (
	input  logic                  CLK,
	input  logic                  RSTn,
	input  logic                  inst_valid,
	input  rv_isa_pkg::instr_t    inst,
	output logic                  wb_valid,
	output rv_isa_pkg::reg_addr_t wb_rd,
	output rv_isa_pkg::word_t     wb_data,
	output rv_isa_pkg::word_t     num_retired
);
	import core_pkg::*;

	dec_ex_t dec;
	result_t ex_res;
	result_t wb_res;

	//////////////////////////////////////////////////////////////////////
	// decode -> execute -> writeback

	decode_stage u_decode (
		.CLK        (CLK),
		.RSTn       (RSTn),
		.inst_valid (inst_valid),
		.inst       (inst),
		.ex_res     (ex_res),	// one instruction older
		.wb_res     (wb_res),	// two older, also the rf write
		.dec        (dec)
	);

	execute_stage u_execute (
		.dec    (dec),
		.ex_res (ex_res)
	);

	writeback_stage u_writeback (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.ex_res      (ex_res),
		.wb_res      (wb_res),
		.num_retired (num_retired)
	);

	assign wb_valid = wb_res.valid;
	assign wb_rd    = wb_res.rd;
	assign wb_data  = wb_res.data;

endmodule

// File: testbench/rv_int_pipe_asserts.sv
`timescale 1ns/10ps

module rv_int_pipe_asserts (
	input logic              CLK,
	input logic              RSTn,
	input logic              inst_valid,
	input logic              wb_valid,
	input rv_isa_pkg::word_t num_retired
);

	//////////////////////////////////////////////////////////////////////
	// output protocol

	// nothing retires right out of reset
	a_quiet_after_reset: assert property (@(posedge CLK) $fell(RSTn) |-> !wb_valid)
		else $error("wb_valid high in the first cycle after reset");

	// counter moves together with wb_valid
	a_retire_count: assert property (@(posedge CLK) disable iff (RSTn)
		num_retired == $past(num_retired) + {31'b0, wb_valid})
		else $error("num_retired out of step with wb_valid");

	a_has_source: assert property (@(posedge CLK) disable iff (RSTn)
		wb_valid |-> $past(inst_valid, 2))
		else $error("wb_valid without an instruction two edges earlier");

endmodule

bind rv_int_pipe rv_int_pipe_asserts u_asserts (
	.CLK         (CLK),
	.RSTn        (RSTn),
	.inst_valid  (inst_valid),
	.wb_valid    (wb_valid),
	.num_retired (num_retired)
);

// File: testbench/tb_rv_int_pipe.sv
`timescale 1ns/10ps

module tb_rv_int_pipe;
	import rv_isa_pkg::*;

	localparam int num_instr      = 400;
	localparam int seed           = 41;
	localparam int timeout_margin = 50;
	localparam int max_cycles     = num_instr * 2 + timeout_margin;

	typedef struct packed {
		logic [31:0] cyc;	// cycle the result must show up
		reg_addr_t   rd;
		word_t       data;
	} exp_t;

	logic      CLK;
	logic      RSTn;
	logic      inst_valid;
	instr_t    inst;
	logic      wb_valid;
	reg_addr_t wb_rd;
	word_t     wb_data;
	word_t     num_retired;

	logic [31:0] cyc;
	logic [31:0] rng;
	word_t       model_regs [32];
	exp_t        exp_q [$];
	exp_t        head;
	int          errors;
	int          checks;
	int          legal_cnt;

	rv_int_pipe DUT (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.num_retired (num_retired)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// random OP or OP-IMM over x0..x7
	function automatic instr_t make_instr(input logic [31:0] r);
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		funct3_t   f3;
		funct7_t   f7;
		rd  = {2'b0, r[2:0]};
		rs1 = {2'b0, r[5:3]};
		rs2 = {2'b0, r[8:6]};
		f3  = r[11:9];
		f7  = (r[12] && (f3 == f3_add || f3 == f3_sr)) ? f7_alt : 7'b0;
		if (r[13])
			return {f7, rs2, rs1, f3, rd, opc_op};
		else if (f3 == f3_sll || f3 == f3_sr)
			return {f7, r[18:14], rs1, f3, rd, opc_op_imm};	// shamt form
		else
			return {r[25:14], rs1, f3, rd, opc_op_imm};
	endfunction

	// sequential RV32I semantics against the model registers
	function automatic word_t ref_result(input instr_t in);
		opcode_t    opc;
		funct3_t    f3;
		logic       alt;
		word_t      a;
		word_t      b;
		logic [4:0] sh;
		word_t      res;
		opc = in[6:0];
		f3  = in[14:12];
		alt = (in[31:25] == f7_alt);
		a   = model_regs[in[19:15]];
		if (opc == opc_op)
			b = model_regs[in[24:20]];
		else
			b = {{20{in[31]}}, in[31:20]};
		sh = b[4:0];
		case (f3)
			f3_add:  res = (opc == opc_op && alt) ? a - b : a + b;
			f3_sll:  res = a << sh;
			f3_slt:  res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			f3_sltu: res = (a < b) ? 32'd1 : 32'd0;
			f3_xor:  res = a ^ b;
			f3_sr: begin
				res = a >> sh;
				if (alt && a[31])
					res = res | ~(32'hffff_ffff >> sh);	// fill with sign
			end
			f3_or:   res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// cycle count and timeout

	always @(posedge CLK) begin
		cyc <= cyc + 32'd1;
		if (cyc >= 32'(max_cycles)) begin
			$display("timeout: the run reached %0d cycles with results still outstanding",
				max_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// compare each retired result with the oldest expected one
	always @(negedge CLK) begin
		if (!RSTn && wb_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("[ERROR] %0t: result for x%0d with nothing outstanding", $time, wb_rd);
			end else begin
				head = exp_q.pop_front();
				check("wb_rd", {27'b0, wb_rd}, {27'b0, head.rd});
				check("wb_data", wb_data, head.data);
				check("result cycle", cyc, head.cyc);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		word_t       res;
		cyc        = '0;
		rng        = 32'(seed);
		errors     = 0;
		checks     = 0;
		legal_cnt  = 0;
		RSTn       = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (5) @(posedge CLK);
		#1 RSTn = 1'b0;

		for (int n = 0; n < num_instr; ) begin
			@(posedge CLK);
			#1;
			rng = xorshift32(rng);
			r   = rng;
			rng = xorshift32(rng);
			s   = rng;
			if (s[9:8] == 2'b00) begin
				inst_valid = 1'b0;	// idle slot
				inst       = r;
			end else begin
				inst_valid = 1'b1;
				inst       = make_instr(r);
				n++;
				if (s % 20 == 0) begin
					// bad opcode, must vanish in decode
					inst[6:0] = s[22:16];
					if (inst[6:0] == opc_op || inst[6:0] == opc_op_imm)
						inst[6] = 1'b1;
				end else begin
					res = ref_result(inst);
					exp_q.push_back('{cyc: cyc + 32'd2, rd: inst[11:7], data: res});
					if (inst[11:7] != 5'd0)
						model_regs[inst[11:7]] = res;
					legal_cnt++;
				end
			end
		end
		@(posedge CLK);
		#1 inst_valid = 1'b0;

		while (exp_q.size() != 0) @(posedge CLK);
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		check("num_retired", num_retired, 32'(legal_cnt));
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: sim.f
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_int_pipe.sv
testbench/rv_int_pipe_asserts.sv
testbench/tb_rv_int_pipe.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the simulation, check the result"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timing --assert -f sim.f --top-module tb_rv_int_pipe
	@out="$$(./obj_dir/Vtb_rv_int_pipe)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
